//--- common/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_addr_t;

    // implemented csr numbers
    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_BADV   = 14'h007;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    localparam logic [5:0] ECODE_INT = 6'h00;
    localparam logic [5:0] ECODE_ADE = 6'h08;
    localparam logic [5:0] ECODE_ALE = 6'h09;

    localparam int TI_BIT = 11;  // timer line in estat/ecfg

    typedef enum logic [2:0] {OP_NONE, OP_CSRRD, OP_CSRWR, OP_CSRXCHG, OP_ERTN} csr_op_e;

    typedef enum logic [1:0] {CMT_NONE, CMT_WRITE, CMT_TRAP, CMT_ERTN} cmt_kind_e;

    typedef struct packed {
        csr_op_e   op;
        csr_addr_t csr_num;
        word_t     wdata;
        word_t     wmask;
        word_t     pc;
    } csr_req_t;

    typedef struct packed {
        logic       valid;
        logic [5:0] ecode;
        logic [8:0] esubcode;
        word_t      pc;
        word_t      badv;
    } excp_t;

    // field order matches the crmd bit layout
    typedef struct packed {
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    typedef struct packed {
        crmd_t       crmd;
        logic [1:0]  prmd_plv;
        logic        prmd_ie;
        logic [12:0] lie;
        logic [1:0]  sw_is;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        word_t       era;
        word_t       badv;
        logic [25:0] eentry;  // bits 31:6
        word_t [3:0] save;
        word_t       tid;
    } csr_state_t;

    typedef struct packed {
        cmt_kind_e  kind;
        csr_addr_t  csr_num;
        word_t      wdata;  // already merged under mask
        logic [5:0] ecode;
        logic [8:0] esubcode;
        word_t      pc;
        word_t      badv;
    } commit_t;

endpackage

//--- hdl/csr_issue.sv
`timescale 1ns/1ns

module csr_issue
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       stall,
    input  logic       kill,
    input  csr_req_t   req,
    input  excp_t      excp,
    input  logic [7:0] hw_int,
    input  csr_state_t state,
    input  logic       ti,
    input  word_t      cur_value,
    input  word_t      merged,
    output commit_t    commit,
    output logic       redirect,
    output word_t      redirect_pc,
    output word_t      rdata
);
    logic [12:0] pending;
    logic        active;
    logic        int_take;
    commit_t     commit_d;
    logic        redirect_d;
    word_t       redirect_pc_d;

    always_comb
    begin
        pending = '0;
        pending[1:0] = state.sw_is;
        pending[9:2] = hw_int;
        pending[TI_BIT] = ti;
    end

    assign active = (req.op != OP_NONE) || excp.valid;
    assign int_take = (|(pending & state.lie)) && state.crmd.ie;

    always_comb
    begin
        commit_d = '0;
        commit_d.csr_num = req.csr_num;
        commit_d.wdata = merged;
        commit_d.pc = req.pc;
        commit_d.badv = req.pc;
        redirect_d = 1'b0;
        redirect_pc_d = req.pc + 32'd4;
        if (active)
        begin
            if (int_take)
            begin
                commit_d.kind = CMT_TRAP;
                commit_d.ecode = ECODE_INT;  // esubcode stays 0
                redirect_d = 1'b1;
                redirect_pc_d = {state.eentry, 6'b0};
            end
            else if (excp.valid)
            begin
                commit_d.kind = CMT_TRAP;
                commit_d.ecode = excp.ecode;
                commit_d.esubcode = excp.esubcode;
                commit_d.pc = excp.pc;
                commit_d.badv = excp.badv;
                redirect_d = 1'b1;
                redirect_pc_d = {state.eentry, 6'b0};
            end
            else if (!kill)
            begin
                case (req.op)
                    OP_CSRWR, OP_CSRXCHG:
                    begin
                        commit_d.kind = CMT_WRITE;
                        redirect_d = 1'b1;
                    end
                    OP_ERTN:
                    begin
                        commit_d.kind = CMT_ERTN;
                        redirect_d = 1'b1;
                        redirect_pc_d = state.era;
                    end
                    default: ;  // csrrd only returns data
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            commit <= '0;
            redirect <= 1'b0;
        end
        else if (!stall)
        begin
            commit <= commit_d;
            redirect <= redirect_d;
        end
        else
            commit.kind <= CMT_NONE;  // a held record must not apply twice
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            redirect_pc <= redirect_pc_d;
            rdata <= cur_value;  // old value
        end
    end

endmodule

//--- hdl/csr_read_mux.sv
`timescale 1ns/1ns

module csr_read_mux
    import csr_pkg::*;
#(
    parameter int TIMER_N = 32
)
(
    input  csr_addr_t          csr_num,
    input  word_t              wdata,
    input  word_t              wmask,
    input  csr_op_e            op,
    input  csr_state_t         state,
    input  logic [TIMER_N-1:0] tcfg,
    input  logic [TIMER_N-1:0] tval,
    input  logic               ti,
    input  logic [7:0]         hw_int,
    output word_t              cur_value,
    output word_t              merged
);
    word_t estat;

    always_comb
    begin
        estat = '0;
        estat[1:0] = state.sw_is;
        estat[9:2] = hw_int;
        estat[TI_BIT] = ti;
        estat[21:16] = state.ecode;
        estat[30:22] = state.esubcode;
    end

    always_comb
    begin
        case (csr_num)
            CSR_CRMD:
                cur_value = {27'b0, state.crmd};
            CSR_PRMD:
                cur_value = {29'b0, state.prmd_ie, state.prmd_plv};
            CSR_ECFG:
                cur_value = {19'b0, state.lie[12:11], 1'b0, state.lie[9:0]};
            CSR_ESTAT:
                cur_value = estat;
            CSR_ERA:
                cur_value = state.era;
            CSR_BADV:
                cur_value = state.badv;
            CSR_EENTRY:
                cur_value = {state.eentry, 6'b0};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                cur_value = state.save[csr_num[1:0]];
            CSR_TID:
                cur_value = state.tid;
            CSR_TCFG:
                cur_value = 32'(tcfg);
            CSR_TVAL:
                cur_value = 32'(tval);
            default:
                cur_value = '0;  // ticlr and unknown numbers
        endcase
    end

    // xchg keeps unmasked bits, csrwr takes the full word
    assign merged = (op == OP_CSRXCHG) ? ((cur_value & ~wmask) | (wdata & wmask)) : wdata;

endmodule

//--- hdl/csr_regfile.sv
`timescale 1ns/1ns

module csr_regfile
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  commit_t    commit,
    output csr_state_t state,
    output crmd_t      crmd,
    output logic       excp_flush,
    output logic       ertn_flush
);
    crmd_t       crmd_q;
    logic [1:0]  prmd_plv;
    logic        prmd_ie;
    logic [12:0] lie;
    logic [1:0]  sw_is;
    logic [5:0]  ecode;
    logic [8:0]  esubcode;
    word_t       era;
    word_t       badv;
    logic [25:0] eentry;
    word_t [3:0] save;
    word_t       tid;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q <= '{pg: 1'b0, da: 1'b1, ie: 1'b0, plv: 2'b00};
            prmd_plv <= '0;
            prmd_ie <= 1'b0;
            lie <= '0;
            sw_is <= '0;
            ecode <= '0;
            esubcode <= '0;
            era <= '0;
            badv <= '0;
            eentry <= '0;
            save <= '0;
            tid <= '0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            excp_flush <= (commit.kind == CMT_TRAP);
            ertn_flush <= (commit.kind == CMT_ERTN);
            case (commit.kind)
                CMT_TRAP:
                begin
                    prmd_plv <= crmd_q.plv;
                    prmd_ie <= crmd_q.ie;
                    crmd_q.plv <= 2'b00;
                    crmd_q.ie <= 1'b0;
                    era <= commit.pc;
                    ecode <= commit.ecode;
                    esubcode <= commit.esubcode;
                    if (commit.ecode == ECODE_ADE || commit.ecode == ECODE_ALE)
                        badv <= commit.badv;  // address faults only
                end
                CMT_ERTN:
                begin
                    crmd_q.plv <= prmd_plv;
                    crmd_q.ie <= prmd_ie;
                end
                CMT_WRITE:
                begin
                    case (commit.csr_num)
                        CSR_CRMD:
                        begin
                            crmd_q.plv <= commit.wdata[1:0];
                            crmd_q.ie <= commit.wdata[2];
                            if (commit.wdata[3] ^ commit.wdata[4])  // da/pg exclusive
                            begin
                                crmd_q.da <= commit.wdata[3];
                                crmd_q.pg <= commit.wdata[4];
                            end
                        end
                        CSR_PRMD:
                        begin
                            prmd_plv <= commit.wdata[1:0];
                            prmd_ie <= commit.wdata[2];
                        end
                        CSR_ECFG:
                            lie <= {commit.wdata[12:11], 1'b0, commit.wdata[9:0]};
                        CSR_ESTAT:
                            sw_is <= commit.wdata[1:0];  // only sw bits writable
                        CSR_ERA:
                            era <= commit.wdata;
                        CSR_BADV:
                            badv <= commit.wdata;
                        CSR_EENTRY:
                            eentry <= commit.wdata[31:6];
                        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                            save[commit.csr_num[1:0]] <= commit.wdata;
                        CSR_TID:
                            tid <= commit.wdata;
                        default: ;  // timer regs live in csr_timer
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_comb
    begin
        state.crmd = crmd_q;
        state.prmd_plv = prmd_plv;
        state.prmd_ie = prmd_ie;
        state.lie = lie;
        state.sw_is = sw_is;
        state.ecode = ecode;
        state.esubcode = esubcode;
        state.era = era;
        state.badv = badv;
        state.eentry = eentry;
        state.save = save;
        state.tid = tid;
    end

    assign crmd = crmd_q;

endmodule

//--- hdl/csr_timer.sv
`timescale 1ns/1ns

module csr_timer
    import csr_pkg::*;
#(
    parameter int TIMER_N = 32
)
(
    input  logic               clk,
    input  logic               rstn,
    input  commit_t            commit,
    output logic [TIMER_N-1:0] tcfg,
    output logic [TIMER_N-1:0] tval,
    output logic               ti
);
    logic tcfg_wr;
    logic ticlr_wr;
    logic expire;

    assign tcfg_wr = (commit.kind == CMT_WRITE) && (commit.csr_num == CSR_TCFG);
    assign ticlr_wr = (commit.kind == CMT_WRITE) && (commit.csr_num == CSR_TICLR)
                      && commit.wdata[0];
    assign expire = tcfg[0] && (tval == TIMER_N'(1));  // last decrement

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            tval <= '0;
            ti <= 1'b0;
        end
        else
        begin
            if (tcfg_wr)
                tcfg <= commit.wdata[TIMER_N-1:0];

            if (tcfg_wr && commit.wdata[0])
                tval <= {commit.wdata[TIMER_N-1:2], 2'b00};
            else if (tcfg[0])
            begin
                if (tval != '0)
                    tval <= tval - 1'b1;
                else if (tcfg[1])
                    tval <= {tcfg[TIMER_N-1:2], 2'b00};  // periodic reload
            end

            ti <= (ti && !ticlr_wr) || expire;
        end
    end

endmodule

//--- hdl/csr_unit.sv
`timescale 1ns/1ns

module csr_unit
    import csr_pkg::*;
#(
    parameter int TIMER_N = 32
)
(
    input  logic       clk,
    input  logic       rstn,
    input  csr_req_t   req,
    input  excp_t      excp,
    input  logic [7:0] hw_int,
    input  logic       stall,
    input  logic       kill,
    output word_t      rdata,
    output logic       redirect,
    output word_t      redirect_pc,
    output logic       excp_flush,
    output logic       ertn_flush,
    output crmd_t      crmd
);
    csr_state_t         state;
    commit_t            commit;
    word_t              cur_value;
    word_t              merged;
    logic [TIMER_N-1:0] tcfg;
    logic [TIMER_N-1:0] tval;
    logic               ti;

    csr_issue issue_i (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .kill       (kill),
        .req        (req),
        .excp       (excp),
        .hw_int     (hw_int),
        .state      (state),
        .ti         (ti),
        .cur_value  (cur_value),
        .merged     (merged),
        .commit     (commit),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .rdata      (rdata)
    );

    csr_read_mux #(.TIMER_N(TIMER_N)) read_mux_i (
        .csr_num  (req.csr_num),
        .wdata    (req.wdata),
        .wmask    (req.wmask),
        .op       (req.op),
        .state    (state),
        .tcfg     (tcfg),
        .tval     (tval),
        .ti       (ti),
        .hw_int   (hw_int),
        .cur_value(cur_value),
        .merged   (merged)
    );

    csr_regfile regfile_i (
        .clk       (clk),
        .rstn      (rstn),
        .commit    (commit),
        .state     (state),
        .crmd      (crmd),
        .excp_flush(excp_flush),
        .ertn_flush(ertn_flush)
    );

    csr_timer #(.TIMER_N(TIMER_N)) timer_i (
        .clk   (clk),
        .rstn  (rstn),
        .commit(commit),
        .tcfg  (tcfg),
        .tval  (tval),
        .ti    (ti)
    );

endmodule

//--- verif/csr_unit_properties.sv
`timescale 1ns/1ns

module csr_unit_properties
(
    input logic clk,
    input logic rstn,
    input logic excp_flush,
    input logic ertn_flush,
    input logic redirect
);
    int fail_count = 0;

    flush_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush))
    else
    begin
        $error("excp_flush and ertn_flush high in the same cycle");
        fail_count++;
    end

    excp_pulse: assert property (@(posedge clk) disable iff (!rstn)
        excp_flush |=> !excp_flush)
    else
    begin
        $error("excp_flush held longer than one cycle");
        fail_count++;
    end

    ertn_pulse: assert property (@(posedge clk) disable iff (!rstn)
        ertn_flush |=> !ertn_flush)
    else
    begin
        $error("ertn_flush held longer than one cycle");
        fail_count++;
    end

    // sync reset, so redirect drops one edge after rstn is seen low
    redirect_in_reset: assert property (@(posedge clk) !rstn |=> !redirect)
    else
    begin
        $error("redirect high during reset");
        fail_count++;
    end

endmodule

bind csr_unit csr_unit_properties props_i (
    .clk       (clk),
    .rstn      (rstn),
    .excp_flush(excp_flush),
    .ertn_flush(ertn_flush),
    .redirect  (redirect)
);

//--- verif/csr_unit_tb.sv
`timescale 1ns/1ns

module csr_unit_tb
    import csr_pkg::*;
();
    localparam int TIMER_N = 32;
    localparam int MAX_STEPS = 64;
    localparam int POLL_LIMIT = 40;
    localparam int STALL_CYCLES = 3;
    localparam word_t ENTRY_W = 32'h1c00_807f;
    localparam word_t ENTRY_R = 32'h1c00_8040;  // low six bits read zero
    localparam word_t EPC = 32'h1c00_1234;
    localparam word_t FAULT_ADDR = 32'h0000_0abd;
    localparam word_t XMASK = 32'h00ff_ff00;

    typedef struct packed {
        csr_req_t   req;
        excp_t      excp;
        logic       kill;
        logic       stall;
        logic       exp_redirect;
        word_t      exp_rpc;
        word_t      exp_rdata;
        logic [1:0] exp_flush;  // {excp, ertn}
        crmd_t      exp_crmd;
    } step_t;

    logic       clk;
    logic       rstn;
    csr_req_t   req;
    excp_t      excp;
    logic [7:0] hw_int;
    logic       stall;
    logic       kill;
    word_t      rdata;
    logic       redirect;
    word_t      redirect_pc;
    logic       excp_flush;
    logic       ertn_flush;
    crmd_t      crmd;

    step_t       tbl [MAX_STEPS];
    int          n_steps;
    int          n_done;
    int          checks;
    int          errors;
    logic [31:0] lfsr;
    word_t       pc;
    crmd_t       crmd_exp;
    logic        timed_out;

    csr_unit #(.TIMER_N(TIMER_N)) dut_i (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .excp       (excp),
        .hw_int     (hw_int),
        .stall      (stall),
        .kill       (kill),
        .rdata      (rdata),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .crmd       (crmd)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output word_t w);
        int i;
        w = '0;
        for (i = 0; i < 32; i++)
        begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_crmd(input string what, input crmd_t got, input crmd_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic add_step(input csr_op_e op, input csr_addr_t num, input word_t wdata,
                            input word_t wmask, input word_t exp_rdata);
        step_t s;
        s = '0;
        s.req.op = op;
        s.req.csr_num = num;
        s.req.wdata = wdata;
        s.req.wmask = wmask;
        s.req.pc = pc;
        s.exp_redirect = (op == OP_CSRWR) || (op == OP_CSRXCHG) || (op == OP_ERTN);
        s.exp_rpc = pc + 32'd4;
        s.exp_rdata = exp_rdata;
        s.exp_crmd = crmd_exp;
        tbl[n_steps] = s;
        n_steps++;
        pc = pc + 32'd4;
    endtask

    task automatic mark_trap();
        tbl[n_steps-1].exp_redirect = 1'b1;
        tbl[n_steps-1].exp_rpc = ENTRY_R;
        tbl[n_steps-1].exp_flush = 2'b10;
    endtask

    task automatic apply_step(input int idx, input step_t s);
        int i;
        @(posedge clk);
        req <= s.req;
        excp <= s.excp;
        kill <= s.kill;
        stall <= s.stall;
        if (s.stall)
        begin
            for (i = 0; i < STALL_CYCLES; i++)
            begin
                @(posedge clk);
                @(negedge clk);
                check_bit($sformatf("step %0d redirect under stall", idx), redirect, 1'b0);
            end
            @(posedge clk);
            stall <= 1'b0;
        end
        @(posedge clk);
        req <= '0;
        excp <= '0;
        kill <= 1'b0;
        @(negedge clk);
        check_bit($sformatf("step %0d redirect", idx), redirect, s.exp_redirect);
        check_word($sformatf("step %0d redirect_pc", idx), redirect_pc, s.exp_rpc);
        check_word($sformatf("step %0d rdata", idx), rdata, s.exp_rdata);
        @(negedge clk);
        check_bit($sformatf("step %0d excp_flush", idx), excp_flush, s.exp_flush[1]);
        check_bit($sformatf("step %0d ertn_flush", idx), ertn_flush, s.exp_flush[0]);
        check_crmd($sformatf("step %0d crmd", idx), crmd, s.exp_crmd);
    endtask

    task automatic run_table();
        while (n_done < n_steps)
        begin
            apply_step(n_done, tbl[n_done]);
            n_done++;
        end
    endtask

    task automatic wait_timer_irq();
        csr_req_t rd;
        int       polls;
        logic     seen;
        rd = '0;
        rd.op = OP_CSRRD;
        rd.csr_num = CSR_ESTAT;
        rd.pc = pc;
        polls = 0;
        seen = 1'b0;
        while (!seen && polls < POLL_LIMIT)
        begin
            @(posedge clk);
            req <= rd;
            @(posedge clk);
            req <= '0;
            @(negedge clk);
            seen = rdata[TI_BIT];
            polls++;
        end
        if (!seen)
            $display("timeout: timer bit never set in ESTAT after %0d reads", POLL_LIMIT);
        timed_out = !seen;
    endtask

    initial
    begin
        word_t r [4];
        word_t x;
        word_t w_kill;
        word_t w_stall;
        word_t int_pc;
        int    i;
        int    n_assert;
        rstn = 1'b0;
        req = '0;
        excp = '0;
        hw_int = '0;
        stall = 1'b0;
        kill = 1'b0;
        n_steps = 0;
        n_done = 0;
        checks = 0;
        errors = 0;
        lfsr = 32'h4342_3867;
        pc = 32'h1c00_0000;
        crmd_exp = 5'h08;  // da only
        timed_out = 1'b0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        for (i = 0; i < 4; i++)
        begin
            rand_word(r[i]);
            add_step(OP_CSRWR, csr_addr_t'(CSR_SAVE0 + i), r[i], '0, '0);
        end
        add_step(OP_CSRWR, CSR_TID, 32'h0000_5a17, '0, '0);
        add_step(OP_CSRWR, CSR_EENTRY, ENTRY_W, '0, '0);
        for (i = 0; i < 4; i++)
            add_step(OP_CSRRD, csr_addr_t'(CSR_SAVE0 + i), '0, '0, r[i]);
        add_step(OP_CSRRD, CSR_TID, '0, '0, 32'h0000_5a17);
        add_step(OP_CSRRD, CSR_EENTRY, '0, '0, ENTRY_R);
        add_step(OP_CSRRD, 14'h3ff, '0, '0, '0);  // not implemented

        rand_word(x);
        add_step(OP_CSRXCHG, CSR_SAVE0, x, XMASK, r[0]);
        add_step(OP_CSRRD, CSR_SAVE0, '0, '0, (r[0] & ~XMASK) | (x & XMASK));

        rand_word(w_kill);
        add_step(OP_CSRWR, CSR_SAVE1, w_kill, '0, r[1]);
        tbl[n_steps-1].kill = 1'b1;
        tbl[n_steps-1].exp_redirect = 1'b0;
        add_step(OP_CSRRD, CSR_SAVE1, '0, '0, r[1]);

        rand_word(w_stall);
        add_step(OP_CSRWR, CSR_SAVE2, w_stall, '0, r[2]);
        tbl[n_steps-1].stall = 1'b1;
        add_step(OP_CSRRD, CSR_SAVE2, '0, '0, w_stall);

        // plv 3 with ie so prmd has something to save
        crmd_exp = 5'h0f;
        add_step(OP_CSRWR, CSR_CRMD, 32'h0000_000f, '0, 32'h0000_0008);
        crmd_exp = 5'h08;
        add_step(OP_NONE, CSR_CRMD, '0, '0, 32'h0000_000f);
        tbl[n_steps-1].excp = '{valid: 1'b1, ecode: ECODE_ALE, esubcode: 9'd0,
                                pc: EPC, badv: FAULT_ADDR};
        mark_trap();
        add_step(OP_CSRRD, CSR_ERA, '0, '0, EPC);
        add_step(OP_CSRRD, CSR_BADV, '0, '0, FAULT_ADDR);
        add_step(OP_CSRRD, CSR_ESTAT, '0, '0, {10'b0, ECODE_ALE, 16'b0});
        add_step(OP_CSRRD, CSR_PRMD, '0, '0, 32'h0000_0007);

        crmd_exp = 5'h0f;
        add_step(OP_ERTN, CSR_CRMD, '0, '0, 32'h0000_0008);
        tbl[n_steps-1].exp_rpc = EPC;
        tbl[n_steps-1].exp_flush = 2'b01;

        crmd_exp = 5'h08;  // ie off while polling
        add_step(OP_CSRWR, CSR_CRMD, 32'h0000_0008, '0, 32'h0000_000f);
        add_step(OP_CSRWR, CSR_ECFG, 32'h0000_0800, '0, '0);
        add_step(OP_CSRWR, CSR_TCFG, 32'h0000_0011, '0, '0);  // one-shot, initval 0x10
        run_table();

        wait_timer_irq();
        if (!timed_out)
        begin
            crmd_exp = 5'h0c;
            add_step(OP_CSRWR, CSR_CRMD, 32'h0000_000c, '0, 32'h0000_0008);
            crmd_exp = 5'h08;
            int_pc = pc;
            add_step(OP_CSRRD, CSR_SAVE3, '0, '0, r[3]);
            mark_trap();
            add_step(OP_CSRRD, CSR_ERA, '0, '0, int_pc);
            add_step(OP_CSRRD, CSR_ESTAT, '0, '0, 32'h0000_0800);
            add_step(OP_CSRRD, CSR_PRMD, '0, '0, 32'h0000_0004);
            add_step(OP_CSRWR, CSR_TICLR, 32'h0000_0001, '0, '0);
            add_step(OP_CSRRD, CSR_ESTAT, '0, '0, '0);
            run_table();
        end

        repeat (2) @(posedge clk);
        n_assert = dut_i.props_i.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 checks, errors, n_assert, timed_out);
        if (errors == 0 && n_assert == 0 && !timed_out)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- src.f
common/csr_pkg.sv
hdl/csr_issue.sv
hdl/csr_read_mux.sv
hdl/csr_regfile.sv
hdl/csr_timer.sv
hdl/csr_unit.sv
verif/csr_unit_properties.sv
verif/csr_unit_tb.sv
